/* adbg_axi_biu.f */
logic/adbg_axi_pkg.sv
logic/adbg_sync_toggle.sv
logic/adbg_tck_request.sv
logic/adbg_axi_master_fsm.sv
logic/adbg_axi_biu.sv
verification/tb_clock_gen.sv
verification/adbg_axi_biu_properties.sv
verification/adbg_axi_biu_tb.sv

/* logic/adbg_axi_biu.sv */
// Debug-port to AXI4 bus interface unit, top level
// The debug side runs on tck_i and the AXI master on axi_aclk
// Strobe only while rdy_o is high; data_o and err_o are valid once rdy_o returns
// AXI sideband fields are not driven and the slave must treat every beat as last

`default_nettype none

module adbg_axi_biu
   import adbg_axi_pkg::*;
#(
   parameter int AXI_ADDR_WIDTH = 32
) (
   // Debug side
   input  logic                      tck_i,
   input  logic                      trstn_i,
   input  data_t                     data_i,
   output data_t                     data_o,
   input  logic [AXI_ADDR_WIDTH-1:0] addr_i,
   input  logic                      strobe_i,
   input  logic                      rd_wrn_i,
   output logic                      rdy_o,
   output logic                      err_o,
   input  word_size_t                word_size_i,
   // AXI clock and reset
   input  logic                      axi_aclk,
   input  logic                      axi_aresetn,
   // Write address
   output logic                      aw_valid_o,
   output logic [AXI_ADDR_WIDTH-1:0] aw_addr_o,
   output axi_size_t                 aw_size_o,
   input  logic                      aw_ready_i,
   // Write data
   output logic                      w_valid_o,
   output data_t                     w_data_o,
   output strb_t                     w_strb_o,
   input  logic                      w_ready_i,
   // Read address
   output logic                      ar_valid_o,
   output logic [AXI_ADDR_WIDTH-1:0] ar_addr_o,
   output axi_size_t                 ar_size_o,
   input  logic                      ar_ready_i,
   // Read data
   input  logic                      r_valid_i,
   input  data_t                     r_data_i,
   input  axi_resp_t                 r_resp_i,
   output logic                      r_ready_o,
   // Write response
   input  logic                      b_valid_i,
   input  axi_resp_t                 b_resp_i,
   output logic                      b_ready_o
);

   // Quasi-static request, TCK domain
   logic [AXI_ADDR_WIDTH-1:0] req_addr;
   strb_t                     req_strb;
   data_t                     req_wdata;
   logic                      req_write;
   axi_size_t                 req_size;

   // Handshake toggles and their synchronized pulses
   logic start_tgl;
   logic start_pulse;
   logic done_tgl;
   logic done_pulse;

   //////////////////////////////////////////////////
   // TCK domain
   //////////////////////////////////////////////////

   adbg_tck_request #(
      .AXI_ADDR_WIDTH (AXI_ADDR_WIDTH)
   ) u_tck_request (
      .tck_i        (tck_i),
      .trstn_i      (trstn_i),
      .strobe_i     (strobe_i),
      .rd_wrn_i     (rd_wrn_i),
      .data_i       (data_i),
      .addr_i       (addr_i),
      .word_size_i  (word_size_i),
      .done_pulse_i (done_pulse),
      .rdy_o        (rdy_o),
      .req_addr_o   (req_addr),
      .req_strb_o   (req_strb),
      .req_wdata_o  (req_wdata),
      .req_write_o  (req_write),
      .req_size_o   (req_size),
      .start_tgl_o  (start_tgl)
   );

   // Completion back into TCK
   adbg_sync_toggle u_done_sync (
      .clk_i   (tck_i),
      .rst_ni  (trstn_i),
      .tgl_i   (done_tgl),
      .pulse_o (done_pulse)
   );

   //////////////////////////////////////////////////
   // AXI domain
   //////////////////////////////////////////////////

   // Start request into axi_aclk
   adbg_sync_toggle u_start_sync (
      .clk_i   (axi_aclk),
      .rst_ni  (axi_aresetn),
      .tgl_i   (start_tgl),
      .pulse_o (start_pulse)
   );

   adbg_axi_master_fsm #(
      .AXI_ADDR_WIDTH (AXI_ADDR_WIDTH)
   ) u_axi_master_fsm (
      .axi_aclk      (axi_aclk),
      .axi_aresetn   (axi_aresetn),
      .start_pulse_i (start_pulse),
      .req_addr_i    (req_addr),
      .req_strb_i    (req_strb),
      .req_wdata_i   (req_wdata),
      .req_write_i   (req_write),
      .req_size_i    (req_size),
      .aw_valid_o    (aw_valid_o),
      .aw_addr_o     (aw_addr_o),
      .aw_size_o     (aw_size_o),
      .aw_ready_i    (aw_ready_i),
      .w_valid_o     (w_valid_o),
      .w_data_o      (w_data_o),
      .w_strb_o      (w_strb_o),
      .w_ready_i     (w_ready_i),
      .ar_valid_o    (ar_valid_o),
      .ar_addr_o     (ar_addr_o),
      .ar_size_o     (ar_size_o),
      .ar_ready_i    (ar_ready_i),
      .r_valid_i     (r_valid_i),
      .r_data_i      (r_data_i),
      .r_resp_i      (r_resp_i),
      .r_ready_o     (r_ready_o),
      .b_valid_i     (b_valid_i),
      .b_resp_i      (b_resp_i),
      .b_ready_o     (b_ready_o),
      .rdata_o       (data_o),
      .err_o         (err_o),
      .done_tgl_o    (done_tgl)
   );

endmodule

`default_nettype wire

/* logic/adbg_axi_master_fsm.sv */
// AXI4 single-beat master FSM for the debug bus interface unit
// Request inputs come from the TCK domain and are stable while an access runs
// AW and W are issued one after the other and every access is one beat
// Read data is returned shifted down to bit 0 and upper bytes are not cleared

`default_nettype none

module adbg_axi_master_fsm
   import adbg_axi_pkg::*;
#(
   parameter int AXI_ADDR_WIDTH = 32
) (
   input  logic                      axi_aclk,
   input  logic                      axi_aresetn,
   input  logic                      start_pulse_i,
   input  logic [AXI_ADDR_WIDTH-1:0] req_addr_i,
   input  strb_t                     req_strb_i,
   input  data_t                     req_wdata_i,
   input  logic                      req_write_i,
   input  axi_size_t                 req_size_i,
   // Write address
   output logic                      aw_valid_o,
   output logic [AXI_ADDR_WIDTH-1:0] aw_addr_o,
   output axi_size_t                 aw_size_o,
   input  logic                      aw_ready_i,
   // Write data
   output logic                      w_valid_o,
   output data_t                     w_data_o,
   output strb_t                     w_strb_o,
   input  logic                      w_ready_i,
   // Read address
   output logic                      ar_valid_o,
   output logic [AXI_ADDR_WIDTH-1:0] ar_addr_o,
   output axi_size_t                 ar_size_o,
   input  logic                      ar_ready_i,
   // Read data
   input  logic                      r_valid_i,
   input  data_t                     r_data_i,
   input  axi_resp_t                 r_resp_i,
   output logic                      r_ready_o,
   // Write response
   input  logic                      b_valid_i,
   input  axi_resp_t                 b_resp_i,
   output logic                      b_ready_o,
   // Results
   output data_t                     rdata_o,
   output logic                      err_o,
   output logic                      done_tgl_o
);

   axi_state_t state_q;
   axi_state_t state_d;

   logic       addr_done;
   logic       resp_done;
   axi_resp_t  resp_sel;
   lane_t      rd_lane;
   data_t      rdata_aligned;

   //////////////////////////////////////////////////
   // Channel outputs
   //////////////////////////////////////////////////

   // Payload straight from the captured request
   assign aw_addr_o = req_addr_i;
   assign ar_addr_o = req_addr_i;
   assign aw_size_o = req_size_i;
   assign ar_size_o = req_size_i;
   assign w_data_o  = req_wdata_i;
   assign w_strb_o  = req_strb_i;

   // Valids and readies follow the state only, so each holds until its handshake
   assign aw_valid_o = (state_q == S_ADDR) && req_write_i;
   assign ar_valid_o = (state_q == S_ADDR) && !req_write_i;
   assign w_valid_o  = (state_q == S_DATA);
   assign b_ready_o  = (state_q == S_RESP) && req_write_i;
   assign r_ready_o  = (state_q == S_RESP) && !req_write_i;

   // Handshakes of the active direction
   assign addr_done = req_write_i ? aw_ready_i : ar_ready_i;
   assign resp_done = (state_q == S_RESP) && (req_write_i ? b_valid_i : r_valid_i);
   assign resp_sel  = req_write_i ? b_resp_i : r_resp_i;

   //////////////////////////////////////////////////
   // Transaction FSM
   //////////////////////////////////////////////////

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         S_IDLE:
            if (start_pulse_i)
               state_d = S_ADDR;
         S_ADDR:
            if (addr_done)
               state_d = req_write_i ? S_DATA : S_RESP;
         S_DATA:
            if (w_ready_i)
               state_d = S_RESP;
         S_RESP:
            if (resp_done)
               state_d = S_IDLE;
         default:
            state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge axi_aclk or negedge axi_aresetn)
   begin
      if (!axi_aresetn)
         state_q <= S_IDLE;
      else
         state_q <= state_d;
   end

   //////////////////////////////////////////////////
   // Read data alignment
   //////////////////////////////////////////////////

   // Lowest enabled lane gives the byte offset
   always_comb
   begin
      rd_lane = '0;
      for (int i = STRB_WIDTH - 1; i >= 0; i--)
      begin
         if (req_strb_i[i])
            rd_lane = lane_t'(i);
      end
   end

   assign rdata_aligned = r_data_i >> {rd_lane, 3'b000};

   //////////////////////////////////////////////////
   // Results back to the debug side
   //////////////////////////////////////////////////

   always_ff @(posedge axi_aclk or negedge axi_aresetn)
   begin
      if (!axi_aresetn)
      begin
         rdata_o    <= '0;
         err_o      <= 1'b0;
         done_tgl_o <= 1'b0;
      end
      else if (resp_done)
      begin
         // Each access overwrites the error flag
         err_o      <= (resp_sel != AXI_RESP_OKAY);
         done_tgl_o <= ~done_tgl_o;
         // Writes leave the last read data in place
         if (!req_write_i)
            rdata_o <= rdata_aligned;
      end
   end

endmodule

`default_nettype wire

/* logic/adbg_axi_pkg.sv */
// Shared widths, vector types and FSM encoding for the debug AXI bus interface unit
// The data path is fixed at 64 bits with eight byte lanes
// Debug word sizes other than 1, 2, 4 or 8 are handled as 8 bytes by the request logic

`default_nettype none

package adbg_axi_pkg;

   //////////////////////////////////////////////////
   // Data path widths
   //////////////////////////////////////////////////

   // AXI and debug data width in bits
   localparam int DATA_WIDTH = 64;

   // One write strobe per byte lane
   localparam int STRB_WIDTH = DATA_WIDTH / 8;

   //////////////////////////////////////////////////
   // Vector types
   //////////////////////////////////////////////////

   typedef logic [DATA_WIDTH-1:0] data_t;
   typedef logic [STRB_WIDTH-1:0] strb_t;

   // Byte offset within one data word
   typedef logic [2:0] lane_t;

   // Word size from the debug transport, in bytes
   typedef logic [3:0] word_size_t;

   // AXI size code, log2 of the byte count
   typedef logic [2:0] axi_size_t;

   // AXI response code
   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

   // Single-beat transaction FSM
   typedef enum logic [1:0] {
      S_IDLE,
      S_ADDR,
      S_DATA,
      S_RESP
   } axi_state_t;

endpackage

`default_nettype wire

/* logic/adbg_sync_toggle.sv */
// Toggle synchronizer into the clk_i domain
// The source must hold each toggle level for at least two destination cycles
// pulse_o lasts one cycle and follows the toggle by 2 to 3 destination cycles

`default_nettype none

module adbg_sync_toggle (
   input  logic clk_i,
   input  logic rst_ni,
   input  logic tgl_i,
   output logic pulse_o
);

   // First stage may go metastable
   logic sync_q1;
   // Settled copy of the toggle
   logic sync_q2;
   // Previous settled value for edge detection
   logic sync_q3;

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         sync_q1 <= 1'b0;
         sync_q2 <= 1'b0;
         sync_q3 <= 1'b0;
      end
      else
      begin
         sync_q1 <= tgl_i;
         sync_q2 <= sync_q1;
         sync_q3 <= sync_q2;
      end
   end

   // Any change of the settled toggle is one event
   assign pulse_o = sync_q2 ^ sync_q3;

endmodule

`default_nettype wire

/* logic/adbg_tck_request.sv */
// TCK-domain request capture for the debug AXI bus interface unit
// Assumes AXI_ADDR_WIDTH of at least 3 and one request in flight at a time
// Short words arrive in the top bytes of data_i and are moved to their byte lanes
// Captured values stay stable until rdy_o rises and are read by the AXI domain

`default_nettype none

module adbg_tck_request
   import adbg_axi_pkg::*;
#(
   parameter int AXI_ADDR_WIDTH = 32
) (
   input  logic                      tck_i,
   input  logic                      trstn_i,
   input  logic                      strobe_i,
   input  logic                      rd_wrn_i,
   input  data_t                     data_i,
   input  logic [AXI_ADDR_WIDTH-1:0] addr_i,
   input  word_size_t                word_size_i,
   input  logic                      done_pulse_i,
   output logic                      rdy_o,
   output logic [AXI_ADDR_WIDTH-1:0] req_addr_o,
   output strb_t                     req_strb_o,
   output data_t                     req_wdata_o,
   output logic                      req_write_o,
   output axi_size_t                 req_size_o,
   output logic                      start_tgl_o
);

   // Decoded from word_size_i
   axi_size_t  size_dec;
   strb_t      strb_base;
   lane_t      align_mask;
   logic [5:0] top_shift;

   // Placed at the addressed offset
   lane_t      lane_dec;
   strb_t      strb_dec;
   data_t      wdata_dec;

   logic       accept;

   //////////////////////////////////////////////////
   // Word size decode
   //////////////////////////////////////////////////

   // Size code, strobe pattern at lane 0, offset alignment and
   // the shift that brings the top bytes of data_i down to bit 0
   always_comb
   begin
      case (word_size_i)
         4'd1:
         begin
            size_dec   = 3'd0;
            strb_base  = 8'h01;
            align_mask = 3'b111;
            top_shift  = 6'd56;
         end
         4'd2:
         begin
            size_dec   = 3'd1;
            strb_base  = 8'h03;
            align_mask = 3'b110;
            top_shift  = 6'd48;
         end
         4'd4:
         begin
            size_dec   = 3'd2;
            strb_base  = 8'h0f;
            align_mask = 3'b100;
            top_shift  = 6'd32;
         end
         default:
         begin
            // 8 bytes and every unsupported size
            size_dec   = 3'd3;
            strb_base  = 8'hff;
            align_mask = 3'b000;
            top_shift  = 6'd0;
         end
      endcase
   end

   //////////////////////////////////////////////////
   // Lane placement
   //////////////////////////////////////////////////

   // Low address bits below the word size are ignored
   assign lane_dec = addr_i[2:0] & align_mask;

   assign strb_dec = strb_base << lane_dec;

   // Top bytes down to bit 0, then up into the masked lanes
   // Alignment keeps the word inside the data bus so no lane wraps
   assign wdata_dec = (data_i >> top_shift) << {lane_dec, 3'b000};

   // A strobe while busy is dropped
   assign accept = strobe_i && rdy_o;

   //////////////////////////////////////////////////
   // Request registers
   //////////////////////////////////////////////////

   // Held from acceptance until the next acceptance
   always_ff @(posedge tck_i)
   begin
      if (accept)
      begin
         req_addr_o  <= addr_i;
         req_strb_o  <= strb_dec;
         req_wdata_o <= wdata_dec;
         req_write_o <= ~rd_wrn_i;
         req_size_o  <= size_dec;
      end
   end

   // Start toggle and ready flag
   always_ff @(posedge tck_i or negedge trstn_i)
   begin
      if (!trstn_i)
      begin
         start_tgl_o <= 1'b0;
         rdy_o       <= 1'b1;
      end
      else if (accept)
      begin
         // One flip per request for the AXI domain
         start_tgl_o <= ~start_tgl_o;
         rdy_o       <= 1'b0;
      end
      else if (done_pulse_i)
      begin
         rdy_o <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the debug AXI bus interface unit testbench with Verilator and runs it.
# Run from the project root. Exits non-zero when the build, the run or the test fails.

LOG=sim.log
BIN=sim_adbg_axi_biu

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f adbg_axi_biu.f \
   --top-module adbg_axi_biu_tb \
   -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* verification/adbg_axi_biu_properties.sv */
// AXI master protocol checks, bound to the transaction FSM
// Covers valid hold until ready, AW and W never together, and a quiet bus after reset

`default_nettype none

module adbg_axi_biu_properties (
   input logic axi_aclk,
   input logic axi_aresetn,
   input logic aw_valid_i,
   input logic aw_ready_i,
   input logic w_valid_i,
   input logic w_ready_i,
   input logic ar_valid_i,
   input logic ar_ready_i,
   input logic b_ready_i,
   input logic r_ready_i
);

   timeunit 1ns;
   timeprecision 1ps;

   //////////////////////////////////////////////////
   // Valid held until ready
   //////////////////////////////////////////////////

   aw_held : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      aw_valid_i && !aw_ready_i |=> aw_valid_i)
      else $error("aw_valid dropped before aw_ready");

   w_held : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      w_valid_i && !w_ready_i |=> w_valid_i)
      else $error("w_valid dropped before w_ready");

   ar_held : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      ar_valid_i && !ar_ready_i |=> ar_valid_i)
      else $error("ar_valid dropped before ar_ready");

   //////////////////////////////////////////////////
   // Sequencing and reset
   //////////////////////////////////////////////////

   // Address goes first, data after it
   aw_w_apart : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      !(aw_valid_i && w_valid_i))
      else $error("aw_valid and w_valid high together");

   quiet_after_reset : assert property (@(posedge axi_aclk)
      $rose(axi_aresetn) |-> !(aw_valid_i || w_valid_i || ar_valid_i || b_ready_i || r_ready_i))
      else $error("AXI valid or ready high right after reset");

endmodule

`default_nettype wire

/* verification/adbg_axi_biu_tb.sv */
// Testbench for the debug-port AXI bus interface unit
// Requests and expected values come from verification/adbg_axi_biu_tests.txt, run from the root
// The AXI slave is modelled here with random stalls of 0 to 3 cycles
// Inputs change 10 ns after the rising edge of their own clock

`default_nettype none

module adbg_axi_biu_tb
   import adbg_axi_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int          TIMEOUT_CYCLES = 64;
   localparam int unsigned SEED           = 32'h95e7_40e8;
   localparam int          SEL_AW         = 0;
   localparam int          SEL_W          = 1;
   localparam int          SEL_AR         = 2;
   localparam int          SEL_B          = 3;
   localparam int          SEL_R          = 4;

   // Clocks and resets
   logic        axi_aclk;
   logic        axi_aresetn;
   logic        tck_i;
   logic        trstn_i;

   // Debug side
   data_t       data_i;
   data_t       data_o;
   logic [31:0] addr_i;
   logic        strobe_i;
   logic        rd_wrn_i;
   logic        rdy_o;
   logic        err_o;
   word_size_t  word_size_i;

   // AXI master ports
   logic        aw_valid_o;
   logic [31:0] aw_addr_o;
   axi_size_t   aw_size_o;
   logic        aw_ready_i;
   logic        w_valid_o;
   data_t       w_data_o;
   strb_t       w_strb_o;
   logic        w_ready_i;
   logic        ar_valid_o;
   logic [31:0] ar_addr_o;
   axi_size_t   ar_size_o;
   logic        ar_ready_i;
   logic        r_valid_i;
   data_t       r_data_i;
   axi_resp_t   r_resp_i;
   logic        r_ready_o;
   logic        b_valid_i;
   axi_resp_t   b_resp_i;
   logic        b_ready_o;

   // Current test, one line of the tests file
   logic [8*24-1:0] test_name;
   logic [3:0]      op;
   word_size_t      size;
   logic [31:0]     addr;
   data_t           wdata;
   axi_resp_t       resp;
   data_t           rdata;
   data_t           exp_data;
   strb_t           exp_strb;

   // Seen by the slave model
   logic [31:0]     cap_addr;
   axi_size_t       cap_size;
   data_t           cap_data;
   strb_t           cap_strb;

   int              test_errs;
   int              errors;
   int              tests_run;
   int              passed;
   logic            timed_out;

   tb_clock_gen u_clock_gen (
      .axi_aclk_o    (axi_aclk),
      .tck_o         (tck_i),
      .axi_aresetn_o (axi_aresetn),
      .trstn_o       (trstn_i)
   );

   adbg_axi_biu #(
      .AXI_ADDR_WIDTH (32)
   ) DUT (.*);

   bind adbg_axi_master_fsm adbg_axi_biu_properties u_properties (
      .axi_aclk    (axi_aclk),
      .axi_aresetn (axi_aresetn),
      .aw_valid_i  (aw_valid_o),
      .aw_ready_i  (aw_ready_i),
      .w_valid_i   (w_valid_o),
      .w_ready_i   (w_ready_i),
      .ar_valid_i  (ar_valid_o),
      .ar_ready_i  (ar_ready_i),
      .b_ready_i   (b_ready_o),
      .r_ready_i   (r_ready_o)
   );

   //////////////////////////////////////////////////
   // Checking helpers
   //////////////////////////////////////////////////

   // AXI size is log2 of the byte count, unknown sizes count as 8 bytes
   function automatic axi_size_t expected_size(input word_size_t bytes);
      case (bytes)
         4'd1:    return 3'd0;
         4'd2:    return 3'd1;
         4'd4:    return 3'd2;
         default: return 3'd3;
      endcase
   endfunction

   task automatic check_value(input string field, input data_t expected, input data_t actual);
      if (expected !== actual)
      begin
         $display("[ERROR] %0s %0s expected %h actual %h", test_name, field, expected, actual);
         test_errs++;
      end
   endtask

   // One result line per test, folded into the totals
   task automatic report_test();
      tests_run++;
      if (test_errs == 0)
      begin
         passed++;
         $display("%0s: ok", test_name);
      end
      else
         $display("%0s: %0d mismatches", test_name, test_errs);
      errors += test_errs;
   endtask

   //////////////////////////////////////////////////
   // AXI slave model
   //////////////////////////////////////////////////

   function automatic logic axi_flag(input int sel);
      case (sel)
         SEL_AW:  return aw_valid_o;
         SEL_W:   return w_valid_o;
         SEL_AR:  return ar_valid_o;
         SEL_B:   return b_ready_o;
         default: return r_ready_o;
      endcase
   endfunction

   // Polls 10 ns after each edge, where DUT outputs are settled
   task automatic wait_axi(input int sel, input string what);
      int t;
      t = 0;
      while (axi_flag(sel) !== 1'b1 && t < TIMEOUT_CYCLES)
      begin
         @(posedge axi_aclk);
         #10;
         t++;
      end
      if (axi_flag(sel) !== 1'b1)
      begin
         $display("[ERROR] %0s: no %0s within %0d cycles", test_name, what, TIMEOUT_CYCLES);
         timed_out = 1'b1;
      end
   endtask

   task automatic random_stall();
      int cycles;
      cycles = $urandom % 4;
      repeat (cycles)
      begin
         @(posedge axi_aclk);
         #10;
      end
   endtask

   task automatic run_write_slave();
      wait_axi(SEL_AW, "aw_valid");
      if (timed_out)
         return;
      random_stall();
      aw_ready_i = 1'b1;
      cap_addr   = aw_addr_o;
      cap_size   = aw_size_o;
      @(posedge axi_aclk);
      #10;
      aw_ready_i = 1'b0;
      // W follows one cycle after the AW handshake
      wait_axi(SEL_W, "w_valid");
      if (timed_out)
         return;
      random_stall();
      w_ready_i = 1'b1;
      cap_data  = w_data_o;
      cap_strb  = w_strb_o;
      @(posedge axi_aclk);
      #10;
      w_ready_i = 1'b0;
      random_stall();
      b_valid_i = 1'b1;
      b_resp_i  = resp;
      wait_axi(SEL_B, "b_ready");
      @(posedge axi_aclk);
      #10;
      b_valid_i = 1'b0;
      b_resp_i  = AXI_RESP_OKAY;
   endtask

   task automatic run_read_slave();
      wait_axi(SEL_AR, "ar_valid");
      if (timed_out)
         return;
      random_stall();
      ar_ready_i = 1'b1;
      cap_addr   = ar_addr_o;
      cap_size   = ar_size_o;
      @(posedge axi_aclk);
      #10;
      ar_ready_i = 1'b0;
      random_stall();
      r_valid_i = 1'b1;
      r_data_i  = rdata;
      r_resp_i  = resp;
      wait_axi(SEL_R, "r_ready");
      @(posedge axi_aclk);
      #10;
      r_valid_i = 1'b0;
      r_resp_i  = AXI_RESP_OKAY;
   endtask

   //////////////////////////////////////////////////
   // Debug-side driver
   //////////////////////////////////////////////////

   // One request, one ignored strobe while busy, then wait for rdy_o
   task automatic drive_request();
      int t;
      t = 0;
      @(posedge tck_i);
      #10;
      while (rdy_o !== 1'b1 && t < TIMEOUT_CYCLES)
      begin
         @(posedge tck_i);
         #10;
         t++;
      end
      if (rdy_o !== 1'b1)
      begin
         $display("[ERROR] %0s: rdy_o not high before the request", test_name);
         timed_out = 1'b1;
         return;
      end
      strobe_i    = 1'b1;
      rd_wrn_i    = (op != 4'h1);
      data_i      = wdata;
      addr_i      = addr;
      word_size_i = size;
      @(posedge tck_i);
      #10;
      strobe_i = 1'b0;
      if (rdy_o !== 1'b0)
      begin
         $display("[ERROR] %0s: rdy_o did not fall when the request was taken", test_name);
         test_errs++;
      end
      // Stray strobe, must not start a second access
      strobe_i = 1'b1;
      addr_i   = addr ^ 32'h0000_0100;
      @(posedge tck_i);
      #10;
      strobe_i = 1'b0;
      t = 0;
      while (rdy_o !== 1'b1 && t < TIMEOUT_CYCLES)
      begin
         @(posedge tck_i);
         #10;
         t++;
      end
      if (rdy_o !== 1'b1)
      begin
         $display("[ERROR] %0s: rdy_o did not return after the access", test_name);
         timed_out = 1'b1;
      end
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      int          fd;
      int          rc;
      int          t;
      string       line;

      void'($urandom(SEED));
      strobe_i    = 1'b0;
      rd_wrn_i    = 1'b1;
      data_i      = '0;
      addr_i      = '0;
      word_size_i = '0;
      aw_ready_i  = 1'b0;
      w_ready_i   = 1'b0;
      ar_ready_i  = 1'b0;
      r_valid_i   = 1'b0;
      r_data_i    = '0;
      r_resp_i    = AXI_RESP_OKAY;
      b_valid_i   = 1'b0;
      b_resp_i    = AXI_RESP_OKAY;
      errors      = 0;
      tests_run   = 0;
      passed      = 0;
      timed_out   = 1'b0;
      test_name   = "reset";
      test_errs   = 0;

      // Both domains out of reset
      t = 0;
      while ((axi_aresetn !== 1'b1 || trstn_i !== 1'b1) && t < TIMEOUT_CYCLES)
      begin
         @(posedge axi_aclk);
         #10;
         t++;
      end
      if (axi_aresetn !== 1'b1 || trstn_i !== 1'b1)
      begin
         $display("[ERROR] resets were never released");
         timed_out = 1'b1;
      end
      check_value("rdy_o", data_t'(1'b1), data_t'(rdy_o));
      check_value("err_o", '0, data_t'(err_o));
      check_value("data_o", '0, data_o);
      check_value("valids", '0, data_t'({aw_valid_o, w_valid_o, ar_valid_o, b_ready_o, r_ready_o}));
      report_test();

      fd = $fopen("verification/adbg_axi_biu_tests.txt", "r");
      if (fd == 0)
      begin
         $display("[ERROR] the tests file could not be opened");
         errors++;
      end
      while (fd != 0 && !$feof(fd) && !timed_out)
      begin
         line = "";
         rc   = $fgets(line, fd);
         if (rc > 0 && line.getc(0) != 8'h23)
         begin
            rc = $sscanf(line, "%s %h %h %h %h %h %h %h %h", test_name, op, size, addr,
                         wdata, resp, rdata, exp_data, exp_strb);
            if (rc == 9)
            begin
               test_errs = 0;
               if (op == 4'h1)
               begin
                  fork
                     drive_request();
                     run_write_slave();
                  join
                  check_value("aw_addr", data_t'(addr), data_t'(cap_addr));
                  check_value("aw_size", data_t'(expected_size(size)), data_t'(cap_size));
                  check_value("w_data", exp_data, cap_data);
                  check_value("w_strb", data_t'(exp_strb), data_t'(cap_strb));
               end
               else
               begin
                  fork
                     drive_request();
                     run_read_slave();
                  join
                  check_value("ar_addr", data_t'(addr), data_t'(cap_addr));
                  check_value("ar_size", data_t'(expected_size(size)), data_t'(cap_size));
                  check_value("data_o", exp_data, data_o);
               end
               check_value("err_o", data_t'(resp != AXI_RESP_OKAY), data_t'(err_o));
               // Short watch for an access started by the stray strobe
               repeat (6)
               begin
                  @(posedge axi_aclk);
                  #10;
                  if (aw_valid_o || ar_valid_o)
                  begin
                     $display("[ERROR] %0s: extra AXI access after the ignored strobe",
                              test_name);
                     test_errs++;
                  end
               end
               if (timed_out)
                  test_errs++;
               report_test();
            end
         end
      end
      if (fd != 0)
         $fclose(fd);
      if (tests_run < 2)
      begin
         $display("[ERROR] no requests were read from the tests file");
         errors++;
      end

      $display("tests %0d, passed %0d, failed %0d", tests_run, passed, tests_run - passed);
      if (errors == 0 && !timed_out)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* verification/adbg_axi_biu_tests.txt */
# name op(1=write,0=read) size addr wdata resp rdata exp_data exp_strb, all hex
# exp_data is w_data for writes and data_o for reads; exp_strb is w_strb, unused on reads
wr_b0 1 1 00001000 1122334455667788 0 0000000000000000 0000000000000011 01
wr_b5 1 1 00001005 1122334455667788 0 0000000000000000 0000110000000000 20
wr_h2 1 2 00002002 1122334455667788 0 0000000000000000 0000000011220000 0c
wr_h7 1 2 00002007 1122334455667788 0 0000000000000000 1122000000000000 c0
wr_w4 1 4 00003004 deadbeefcafef00d 0 0000000000000000 deadbeef00000000 f0
wr_w1 1 4 00003001 deadbeefcafef00d 0 0000000000000000 00000000deadbeef 0f
wr_d0 1 8 00004000 0123456789abcdef 0 0000000000000000 0123456789abcdef ff
wr_err 1 4 00005000 a5a5a5a55a5a5a5a 2 0000000000000000 00000000a5a5a5a5 0f
wr_ok_clr 1 8 00005008 0f0f0f0ff0f0f0f0 0 0000000000000000 0f0f0f0ff0f0f0f0 ff
wr_sz3 1 3 00006003 8877665544332211 0 0000000000000000 8877665544332211 ff
wr_szf 1 f 00006010 13579bdf2468ace0 0 0000000000000000 13579bdf2468ace0 ff
rd_b0 0 1 00007000 0000000000000000 0 8877665544332211 8877665544332211 00
rd_b3 0 1 00007003 0000000000000000 0 8877665544332211 0000008877665544 00
rd_h6 0 2 00007006 0000000000000000 0 8877665544332211 0000000000008877 00
rd_w4 0 4 00007004 0000000000000000 0 8877665544332211 0000000088776655 00
rd_w6 0 4 00007006 0000000000000000 0 a1b2c3d4e5f60718 00000000a1b2c3d4 00
rd_d0 0 8 00007008 0000000000000000 0 fedcba9876543210 fedcba9876543210 00
rd_err 0 4 00008000 0000000000000000 3 00000000cafebabe 00000000cafebabe 00
rd_ok_clr 0 2 00008002 0000000000000000 0 1234567890abcdef 00001234567890ab 00
rd_sz9 0 9 00008005 0000000000000000 0 0102030405060708 0102030405060708 00

/* verification/tb_clock_gen.sv */
// Clock and reset source for the bus interface unit testbench
// axi_aclk runs at 100 ns and TCK at 130 ns, so the two domains drift
// Each reset is held for 5 cycles of its own clock

`default_nettype none

module tb_clock_gen (
   output logic axi_aclk_o,
   output logic tck_o,
   output logic axi_aresetn_o,
   output logic trstn_o
);

   timeunit 1ns;
   timeprecision 1ps;

   initial
   begin
      axi_aclk_o = 1'b0;
      forever #50 axi_aclk_o = ~axi_aclk_o;
   end

   initial
   begin
      tck_o = 1'b0;
      forever #65 tck_o = ~tck_o;
   end

   // Release away from the edge, like every other input
   initial
   begin
      axi_aresetn_o = 1'b0;
      repeat (5) @(posedge axi_aclk_o);
      #10;
      axi_aresetn_o = 1'b1;
   end

   initial
   begin
      trstn_o = 1'b0;
      repeat (5) @(posedge tck_o);
      #10;
      trstn_o = 1'b1;
   end

endmodule

`default_nettype wire
